// ==== hdl/core_dbg_fsm.sv ====
`timescale 1ns/1ps

module core_dbg_fsm import debug_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    ebreak_i,
    input  logic    trap_i,
    input  logic    retire_i,
    input  logic    haltreq_i,
    input  logic    resumereq_i,
    dbg_ctl_if.ctl  ctl,
    output logic    running_o,
    output logic    halted_o,
    output logic    resumeack_o,
    output logic    dbg_ret_o,
    output logic    dont_trap_o
);

    dbg_state_e state_q;
    dbg_state_e state_d;
    logic       prev_running_q;
    logic       ebreak_hit;
    logic       haltreq_hit;
    logic       step_hit;
    logic       halt_event;

    // the three halt causes only count while running
    assign ebreak_hit  = ebreak_i && ctl.ebreakm;
    assign haltreq_hit = haltreq_i && (retire_i || trap_i);
    assign step_hit    = ctl.step && (retire_i || trap_i);
    assign halt_event  = running_o && (ebreak_hit || haltreq_hit || step_hit);

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= RUNNING;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        case (state_q)
            RUNNING: state_d = halt_event ? HALTED : RUNNING;
            HALTED:  state_d = resumereq_i ? RESUME : HALTED;
            RESUME:  state_d = resumereq_i ? RESUME : RUNNING;  // wait for the request to drop
            default: state_d = RUNNING;
        endcase
    end

    // cause and dpc source for the capture pulse
    always_comb
    begin
        if (ebreak_hit)
        begin
            ctl.cause = DBG_EBREAK;
        end
        else if (haltreq_hit)
        begin
            ctl.cause = DBG_HALTREQ;
        end
        else
        begin
            ctl.cause = DBG_STEP;
        end
        if (ebreak_hit || retire_i)
        begin
            ctl.capture_src = CAP_RETIRE;
        end
        else
        begin
            ctl.capture_src = CAP_TRAP;
        end
    end

    assign ctl.capture = halt_event;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            prev_running_q <= 1'b1;
        end
        else
        begin
            prev_running_q <= running_o;
        end
    end

    assign running_o   = (state_q == RUNNING);
    assign halted_o    = (state_q == HALTED) || (state_q == RESUME);
    assign resumeack_o = (state_q == RESUME);
    assign dbg_ret_o   = running_o && !prev_running_q;  // first cycle back in RUNNING
    assign dont_trap_o = halt_event;                    // core must not take the trap itself

    // the unused state encoding would leave the core neither running nor halted
    a_run_halt_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot({running_o, halted_o}));

    // a capture is only taken while running and always ends in a fresh halt
    a_capture_running: assert property (@(posedge clk_i) disable iff (reset_i)
        ctl.capture |=> $rose(halted_o));

endmodule : core_dbg_fsm

// ==== hdl/core_debug_unit.sv ====
`timescale 1ns/1ps

module core_debug_unit import debug_pkg::*;
#(
    parameter logic [31:0] DPC_RESET = 32'h0000_0000
)
(
    input  logic        clk_i,
    input  logic        reset_i,

    // core events
    input  logic        ebreak_i,
    input  logic        trap_i,
    input  logic        retire_i,
    input  logic [31:0] retire_pc_i,
    input  logic [31:0] trap_pc_i,

    // run control from the debug module
    input  logic        haltreq_i,
    input  logic        resumereq_i,

    output logic        running_o,
    output logic        halted_o,
    output logic        resumeack_o,
    output logic        dbg_ret_o,
    output logic        dont_trap_o,
    output logic [31:0] dcsr_o,
    output logic [31:0] dpc_o,

    // abstract command channel from the host
    input  logic        cmd_valid_i,
    input  ar_op_e      cmd_op_i,
    input  logic [15:0] cmd_addr_i,
    input  logic [31:0] cmd_wdata_i,
    output logic        cmd_ready_o,
    output logic        rsp_valid_o,
    output logic [31:0] rsp_data_o,
    output ar_err_e     rsp_err_o,
    input  logic        rsp_ready_i
);

    dbg_ar_if  ar_if ();
    dbg_ctl_if ctl_if ();

    core_dbg_fsm core_dbg_fsm_i
    (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .ebreak_i    (ebreak_i),
        .trap_i      (trap_i),
        .retire_i    (retire_i),
        .haltreq_i   (haltreq_i),
        .resumereq_i (resumereq_i),
        .ctl         (ctl_if.ctl),
        .running_o   (running_o),
        .halted_o    (halted_o),
        .resumeack_o (resumeack_o),
        .dbg_ret_o   (dbg_ret_o),
        .dont_trap_o (dont_trap_o)
    );

    dbg_csr_file #(
        .DPC_RESET (DPC_RESET)
    ) dbg_csr_file_i
    (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .retire_pc_i (retire_pc_i),
        .trap_pc_i   (trap_pc_i),
        .ar          (ar_if.regs),
        .ctl         (ctl_if.csr),
        .dcsr_o      (dcsr_o),
        .dpc_o       (dpc_o)
    );

    dbg_abstract_cmd dbg_abstract_cmd_i
    (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .halted_i    (halted_o),
        .cmd_valid_i (cmd_valid_i),
        .cmd_op_i    (cmd_op_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_wdata_i (cmd_wdata_i),
        .cmd_ready_o (cmd_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o),
        .rsp_err_o   (rsp_err_o),
        .rsp_ready_i (rsp_ready_i),
        .ar          (ar_if.engine)
    );

endmodule : core_debug_unit

// ==== hdl/dbg_abstract_cmd.sv ====
`timescale 1ns/1ps

module dbg_abstract_cmd import debug_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        halted_i,
    input  logic        cmd_valid_i,
    input  ar_op_e      cmd_op_i,
    input  logic [15:0] cmd_addr_i,
    input  logic [31:0] cmd_wdata_i,
    output logic        cmd_ready_o,
    output logic        rsp_valid_o,
    output logic [31:0] rsp_data_o,
    output ar_err_e     rsp_err_o,
    input  logic        rsp_ready_i,
    dbg_ar_if.engine    ar
);

    logic        rsp_valid_q;
    logic [31:0] rsp_data_q;
    ar_err_e     rsp_err_q;
    logic        accept;

    // one command in flight, the next is taken once the response has left
    assign cmd_ready_o = !rsp_valid_q;
    assign accept      = cmd_valid_i && cmd_ready_o;

    // register access only happens for a command accepted while halted
    assign ar.en    = accept && halted_i;
    assign ar.wr    = (cmd_op_i == AR_WRITE);
    assign ar.addr  = cmd_addr_i;
    assign ar.wdata = cmd_wdata_i;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            rsp_valid_q <= 1'b0;
        end
        else if (accept)
        begin
            rsp_valid_q <= 1'b1;
        end
        else if (rsp_ready_i)
        begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (accept)
        begin
            if (!halted_i)
            begin
                rsp_data_q <= 32'd0;
                rsp_err_q  <= ERR_NOT_HALTED;
            end
            else
            begin
                rsp_data_q <= (cmd_op_i == AR_READ) ? ar.rdata : 32'd0;
                rsp_err_q  <= ar.bad_addr ? ERR_BAD_REG : ERR_NONE;
            end
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_data_o  = rsp_data_q;
    assign rsp_err_o   = rsp_err_q;

    // a stalled response holds its payload until the host takes it
    a_rsp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (rsp_valid_o && !rsp_ready_i) |=>
            (rsp_valid_o && $stable(rsp_data_o) && $stable(rsp_err_o)));

endmodule : dbg_abstract_cmd

// ==== hdl/dbg_csr_file.sv ====
`timescale 1ns/1ps

module dbg_csr_file import debug_pkg::*;
#(
    parameter logic [31:0] DPC_RESET = 32'h0000_0000
)
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic [31:0] retire_pc_i,
    input  logic [31:0] trap_pc_i,
    dbg_ar_if.regs      ar,
    dbg_ctl_if.csr      ctl,
    output logic [31:0] dcsr_o,
    output logic [31:0] dpc_o
);

    logic        ebreakm_q;
    logic [4:0]  dcsr_13_9_q;   // stopcount, stoptime and friends, stored only
    logic        dcsr_4_q;
    logic        step_q;
    dcause_e     cause_q;
    logic [31:0] dpc_q;
    logic [31:0] dscratch0_q;
    logic        wr_dcsr;
    logic        wr_dpc;
    logic        wr_dscratch0;

    assign wr_dcsr      = ar.en && ar.wr && (ar.addr == CSR_DCSR);
    assign wr_dpc       = ar.en && ar.wr && (ar.addr == CSR_DPC);
    assign wr_dscratch0 = ar.en && ar.wr && (ar.addr == CSR_DSCRATCH0);

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ebreakm_q   <= 1'b0;
            dcsr_13_9_q <= 5'd0;
            dcsr_4_q    <= 1'b0;
            step_q      <= 1'b0;
            cause_q     <= NO_DBG_CAUSE;
            dscratch0_q <= 32'd0;
        end
        else
        begin
            if (wr_dcsr)
            begin
                ebreakm_q   <= ar.wdata[15];
                dcsr_13_9_q <= ar.wdata[13:9];
                dcsr_4_q    <= ar.wdata[4];
                step_q      <= ar.wdata[2];
            end
            if (ctl.capture)
            begin
                cause_q <= ctl.cause;   // cause is read-only to the host
            end
            if (wr_dscratch0)
            begin
                dscratch0_q <= ar.wdata;
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            dpc_q <= DPC_RESET;
        end
        else if (wr_dpc)
        begin
            dpc_q <= ar.wdata;
        end
        else if (ctl.capture)
        begin
            dpc_q <= (ctl.capture_src == CAP_RETIRE) ? retire_pc_i : trap_pc_i;
        end
    end

    assign dcsr_o = {DCSR_XDEBUGVER, 12'd0, ebreakm_q, 1'b0, dcsr_13_9_q, cause_q,
                     1'b0, dcsr_4_q, 1'b0, step_q, DCSR_PRV_M};
    assign dpc_o  = dpc_q;

    always_comb
    begin
        ar.bad_addr = 1'b0;
        case (ar.addr)
            CSR_DCSR:      ar.rdata = dcsr_o;
            CSR_DPC:       ar.rdata = dpc_q;
            CSR_DSCRATCH0: ar.rdata = dscratch0_q;
            default:
            begin
                ar.rdata    = 32'd0;
                ar.bad_addr = 1'b1;
            end
        endcase
    end

    assign ctl.step    = step_q;
    assign ctl.ebreakm = ebreakm_q;

    // host writes only land while halted and captures only fire while running
    a_no_capture_on_dcsr_write: assert property (@(posedge clk_i) disable iff (reset_i)
        !(ctl.capture && wr_dcsr));

endmodule : dbg_csr_file

// ==== hdl/dbg_ifs.sv ====
`timescale 1ns/1ps

// single cycle register access from the command engine to the CSR file
interface dbg_ar_if;
    logic        en;
    logic        wr;
    logic [15:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;     // valid in the same cycle as en
    logic        bad_addr;

    modport engine
    (
        output en, wr, addr, wdata,
        input  rdata, bad_addr
    );

    modport regs
    (
        input  en, wr, addr, wdata,
        output rdata, bad_addr
    );
endinterface : dbg_ar_if

// halt capture request from the FSM and dcsr control bits going back
interface dbg_ctl_if import debug_pkg::*;;
    logic         capture;
    capture_src_e capture_src;
    dcause_e      cause;
    logic         step;     // dcsr[2]
    logic         ebreakm;  // dcsr[15]

    modport ctl
    (
        output capture, capture_src, cause,
        input  step, ebreakm
    );

    modport csr
    (
        input  capture, capture_src, cause,
        output step, ebreakm
    );
endinterface : dbg_ctl_if

// ==== hdl/debug_pkg.sv ====
package debug_pkg;

    // halt cause as reported in the dcsr cause field
    typedef enum logic [2:0]
    {
        NO_DBG_CAUSE = 3'd0,
        DBG_EBREAK   = 3'd1,
        DBG_HALTREQ  = 3'd3,
        DBG_STEP     = 3'd4
    } dcause_e;

    // debug control FSM states, RESUME still counts as halted
    typedef enum logic [1:0]
    {
        RUNNING = 2'd0,
        HALTED  = 2'd1,
        RESUME  = 2'd2
    } dbg_state_e;

    // abstract register command opcode
    typedef enum logic
    {
        AR_READ  = 1'b0,
        AR_WRITE = 1'b1
    } ar_op_e;

    // abstract command result code
    typedef enum logic [1:0]
    {
        ERR_NONE       = 2'd0,
        ERR_NOT_HALTED = 2'd1,
        ERR_BAD_REG    = 2'd2
    } ar_err_e;

    // where dpc is loaded from when the core halts
    typedef enum logic
    {
        CAP_RETIRE = 1'b0,  // pc of the retiring instruction
        CAP_TRAP   = 1'b1   // trap target pc
    } capture_src_e;

    // abstract register numbers of the debug CSRs
    localparam logic [15:0] CSR_DCSR      = 16'h07b0;
    localparam logic [15:0] CSR_DPC       = 16'h07b1;
    localparam logic [15:0] CSR_DSCRATCH0 = 16'h07b2;

    // external debug support version reported in dcsr[31:28]
    localparam logic [3:0] DCSR_XDEBUGVER = 4'd4;

    // prv field is hardwired to machine mode
    localparam logic [1:0] DCSR_PRV_M = 2'd3;

endpackage : debug_pkg

// ==== tb.f ====
+incdir+verif
hdl/debug_pkg.sv
hdl/dbg_ifs.sv
hdl/core_dbg_fsm.sv
hdl/dbg_csr_file.sv
hdl/dbg_abstract_cmd.sv
hdl/core_debug_unit.sv
verif/tb_core_debug_unit.sv

// ==== verif/dbg_tests.svh ====
// one host command that returns the response payload seen one cycle after acceptance
task automatic run_cmd(input ar_op_e op, input logic [15:0] addr, input logic [31:0] wdata,
                       output logic [31:0] data, output ar_err_e err);
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_op_i <= op;
    cmd_addr_i <= addr;
    cmd_wdata_i <= wdata;
    @(negedge clk_i);
    while (!cmd_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    @(negedge clk_i);
    if (!rsp_valid_o)
    begin
        errors++;
        $display("no response one cycle after the command was accepted");
    end
    data = rsp_data_o;
    err = rsp_err_o;
endtask

// one cycle of core events that must halt the core
task automatic core_event(input logic ebreak, trap, retire, haltreq,
                          input logic [31:0] rpc, tpc);
    @(posedge clk_i);
    ebreak_i <= ebreak;
    trap_i <= trap;
    retire_i <= retire;
    haltreq_i <= haltreq;
    retire_pc_i <= rpc;
    trap_pc_i <= tpc;
    @(negedge clk_i);
    check_bit("dont_trap_o", dont_trap_o, 1'b1);
    check_bit("halted_o", halted_o, 1'b0);
    @(posedge clk_i);
    {ebreak_i, trap_i, retire_i, haltreq_i} <= 4'd0;
    @(negedge clk_i);
    check_bit("halted_o", halted_o, 1'b1);
    check_bit("running_o", running_o, 1'b0);
endtask

task automatic resume_core();
    @(posedge clk_i);
    resumereq_i <= 1'b1;
    @(negedge clk_i);
    while (!resumeack_o) @(negedge clk_i);
    @(posedge clk_i);
    resumereq_i <= 1'b0;
    @(negedge clk_i);
    while (!running_o) @(negedge clk_i);
endtask

task automatic test_reset_values();
    int start;
    logic [31:0] pc, data;
    ar_err_e err;
    start = errors;
    check_bit("running_o", running_o, 1'b1);
    check_bit("halted_o", halted_o, 1'b0);
    check_bit("cmd_ready_o", cmd_ready_o, 1'b1);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("resumeack_o", resumeack_o, 1'b0);
    check_bit("dbg_ret_o", dbg_ret_o, 1'b0);
    check_bit("dont_trap_o", dont_trap_o, 1'b0);
    check_word("dpc_o", dpc_o, 32'h0000_1000);
    check_word("dcsr_o", dcsr_o, dcsr_view(32'd0, NO_DBG_CAUSE));
    pc = $random(seed);
    core_event(1'b0, 1'b0, 1'b1, 1'b1, pc, ~pc);
    run_cmd(AR_READ, CSR_DPC, 32'd0, data, err);
    check_err("rsp_err_o", err, ERR_NONE);
    check_word("rsp_data_o", data, pc);
    resume_core();
    report_test("reset values", start);
endtask

task automatic test_running_cmds();
    int start;
    logic [31:0] data;
    ar_err_e err;
    start = errors;
    run_cmd(AR_WRITE, CSR_DSCRATCH0, $random(seed), data, err);
    check_err("rsp_err_o", err, ERR_NOT_HALTED);
    run_cmd(AR_READ, CSR_DPC, 32'd0, data, err);
    check_err("rsp_err_o", err, ERR_NOT_HALTED);
    core_event(1'b0, 1'b0, 1'b1, 1'b1, 32'h0000_2000, 32'd0);
    run_cmd(AR_READ, CSR_DSCRATCH0, 32'd0, data, err);
    check_err("rsp_err_o", err, ERR_NONE);
    check_word("rsp_data_o", data, 32'd0);
    resume_core();
    report_test("commands while running", start);
endtask

task automatic test_halt_request();
    int start;
    logic [31:0] rpc, tpc, data;
    ar_err_e err;
    start = errors;
    rpc = $random(seed);
    tpc = $random(seed);
    core_event(1'b0, 1'b0, 1'b1, 1'b1, rpc, tpc);
    check_cause("dcsr_o cause", dcause_e'(dcsr_o[8:6]), DBG_HALTREQ);
    run_cmd(AR_READ, CSR_DPC, 32'd0, data, err);
    check_word("rsp_data_o", data, rpc);
    resume_core();
    rpc = $random(seed);
    tpc = $random(seed);
    core_event(1'b0, 1'b1, 1'b0, 1'b1, rpc, tpc);     // trap alone takes the trap target
    check_word("dpc_o", dpc_o, tpc);
    check_cause("dcsr_o cause", dcause_e'(dcsr_o[8:6]), DBG_HALTREQ);
    resume_core();
    report_test("halt request", start);
endtask

task automatic test_register_access();
    int start;
    logic [31:0] wd, data;
    ar_err_e err;
    start = errors;
    core_event(1'b0, 1'b0, 1'b1, 1'b1, $random(seed), 32'd0);
    wd = $random(seed);
    run_cmd(AR_WRITE, CSR_DCSR, wd, data, err);
    check_err("rsp_err_o", err, ERR_NONE);
    check_word("dcsr_o", dcsr_o, dcsr_view(wd, DBG_HALTREQ));
    wd = $random(seed);
    run_cmd(AR_WRITE, CSR_DSCRATCH0, wd, data, err);
    run_cmd(AR_READ, CSR_DSCRATCH0, 32'd0, data, err);
    check_word("rsp_data_o", data, wd);
    run_cmd(AR_READ, 16'h07b5, 32'd0, data, err);
    check_err("rsp_err_o", err, ERR_BAD_REG);
    @(posedge clk_i);
    rsp_ready_i <= 1'b0;
    run_cmd(AR_READ, CSR_DSCRATCH0, 32'd0, data, err);
    repeat (4)
    begin
        @(negedge clk_i);
        check_bit("rsp_valid_o", rsp_valid_o, 1'b1);
        check_bit("cmd_ready_o", cmd_ready_o, 1'b0);
        check_word("rsp_data_o", rsp_data_o, wd);
    end
    @(posedge clk_i);
    rsp_ready_i <= 1'b1;
    @(negedge clk_i);
    @(negedge clk_i);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("cmd_ready_o", cmd_ready_o, 1'b1);
    run_cmd(AR_WRITE, CSR_DCSR, 32'd0, data, err);    // clear step and ebreakm again
    report_test("register access", start);
endtask

// starts halted as left by the register access test
task automatic test_resume();
    int start;
    start = errors;
    check_bit("resumeack_o", resumeack_o, 1'b0);
    @(posedge clk_i);
    resumereq_i <= 1'b1;
    @(negedge clk_i);
    check_bit("resumeack_o", resumeack_o, 1'b0);   // the ack comes after the next edge
    repeat (3)
    begin
        @(negedge clk_i);
        check_bit("resumeack_o", resumeack_o, 1'b1);
        check_bit("running_o", running_o, 1'b0);
    end
    @(posedge clk_i);
    resumereq_i <= 1'b0;
    @(negedge clk_i);
    check_bit("running_o", running_o, 1'b0);
    @(negedge clk_i);
    check_bit("running_o", running_o, 1'b1);
    check_bit("resumeack_o", resumeack_o, 1'b0);
    check_bit("dbg_ret_o", dbg_ret_o, 1'b1);
    @(negedge clk_i);
    check_bit("dbg_ret_o", dbg_ret_o, 1'b0);
    report_test("resume handshake", start);
endtask

task automatic test_ebreak_step();
    int start;
    logic [31:0] pc, data;
    ar_err_e err;
    start = errors;
    core_event(1'b0, 1'b0, 1'b1, 1'b1, 32'h0000_3000, 32'd0);
    run_cmd(AR_WRITE, CSR_DCSR, 32'h0000_8000, data, err);
    resume_core();
    pc = $random(seed);
    core_event(1'b1, 1'b0, 1'b1, 1'b0, pc, ~pc);
    check_cause("dcsr_o cause", dcause_e'(dcsr_o[8:6]), DBG_EBREAK);
    check_word("dpc_o", dpc_o, pc);
    run_cmd(AR_WRITE, CSR_DCSR, 32'h0000_0004, data, err);
    resume_core();
    pc = $random(seed);
    core_event(1'b0, 1'b0, 1'b1, 1'b0, pc, ~pc);
    check_cause("dcsr_o cause", dcause_e'(dcsr_o[8:6]), DBG_STEP);
    run_cmd(AR_READ, CSR_DPC, 32'd0, data, err);
    check_word("rsp_data_o", data, pc);
    report_test("ebreak and step", start);
endtask

// ==== verif/tb_core_debug_unit.sv ====
`timescale 1ns/1ps

module tb_core_debug_unit import debug_pkg::*;;

    localparam int TIMEOUT_CYCLES = 4000;   // six directed tests take a few hundred cycles

    logic        clk_i, reset_i;
    logic        ebreak_i, trap_i, retire_i, haltreq_i, resumereq_i;
    logic [31:0] retire_pc_i, trap_pc_i;
    logic        running_o, halted_o, resumeack_o, dbg_ret_o, dont_trap_o;
    logic [31:0] dcsr_o, dpc_o;
    logic        cmd_valid_i, cmd_ready_o, rsp_valid_o, rsp_ready_i;
    ar_op_e      cmd_op_i;
    logic [15:0] cmd_addr_i;
    logic [31:0] cmd_wdata_i, rsp_data_o;
    ar_err_e     rsp_err_o;
    integer      seed;
    int          errors = 0;
    int          tests_run = 0;
    int          cycles = 0;

    core_debug_unit #(.DPC_RESET(32'h0000_1000)) core_debug_unit_i (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_err(input string name, input ar_err_e got, input ar_err_e exp);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_cause(input string name, input dcause_e got, input dcause_e exp);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // what dcsr should read as after the host wrote wd
    function automatic logic [31:0] dcsr_view(input logic [31:0] wd, input dcause_e cause);
        logic [31:0] v;
        v = 32'd0;
        v[31:28] = 4'd4;
        v[15] = wd[15];
        v[13:9] = wd[13:9];
        v[8:6] = cause;
        v[4] = wd[4];
        v[2] = wd[2];
        v[1:0] = 2'd3;  // prv is always machine mode
        return v;
    endfunction

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors)
            $display("test %s: passed", name);
        else
            $display("test %s: failed with %0d errors", name, errors - start_errors);
    endtask

    `include "dbg_tests.svh"

    initial
    begin
        seed = 32'h5898;
        reset_i = 1'b1;
        {ebreak_i, trap_i, retire_i, haltreq_i, resumereq_i} = 5'd0;
        retire_pc_i = 32'd0;
        trap_pc_i = 32'd0;
        cmd_valid_i = 1'b0;
        cmd_op_i = AR_READ;
        cmd_addr_i = 16'd0;
        cmd_wdata_i = 32'd0;
        rsp_ready_i = 1'b1;
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        test_reset_values();
        test_running_cmds();
        test_halt_request();
        test_register_access();
        test_resume();
        test_ebreak_step();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule : tb_core_debug_unit
